/* hw/aluController.sv */
module aluController (
    input  cr16Pkg::operT            oper,
    input  logic [3:0]               func,
    output cr16Pkg::aluOpT           aluOp,
    output logic [cr16Pkg::psrW-1:0] psrEn,
    output cr16Pkg::immKindT         immKind,
    output logic                     regWrite
);
    import cr16Pkg::*;

    always_comb begin
        // defaults double as the don't care decode
        aluOp    = aluAdd;
        psrEn    = '0;
        immKind  = immNone;
        regWrite = 1'b0;
        case (oper)
            opReg: begin
                regWrite = 1'b1;
                case (func)
                    4'b0001: begin aluOp = aluAnd; psrEn = enLogic; end
                    4'b0010: begin aluOp = aluOr;  psrEn = enLogic; end
                    4'b0011: begin aluOp = aluXor; psrEn = enLogic; end
                    4'b0100: begin aluOp = aluNot; psrEn = enLogic; end
                    4'b0101: psrEn = enArith;                   // add
                    4'b0111: aluOp = aluAdd;                    // addu, flags untouched
                    4'b1001: begin aluOp = aluSub; psrEn = enArith; end
                    4'b1101: aluOp = aluMov;
                    4'b1110: aluOp = aluMul;                    // low half only
                    4'b1011: begin                              // cmp
                        aluOp    = aluSub;
                        psrEn    = enCmp;
                        regWrite = 1'b0;
                    end
                    4'b1111: begin                              // test = and, no write
                        aluOp    = aluAnd;
                        psrEn    = enLogic;
                        regWrite = 1'b0;
                    end
                    default: regWrite = 1'b0;                   // addc, subc, unused
                endcase
            end
            opSpecial: begin
                case (func)
                    4'b1100: aluOp = aluJcond;                  // target from src reg
                    4'b1101: begin
                        aluOp    = aluScond;
                        regWrite = 1'b1;
                    end
                    default: aluOp = aluAdd;                    // loads, stores, jal
                endcase
            end
            opShift: begin
                regWrite = 1'b1;
                immKind  = immShamt;
                case (func)
                    4'b0000: aluOp = aluShlImm;                 // lshi left
                    4'b0001: aluOp = aluShrImm;                 // lshi right
                    4'b0010: aluOp = aluShlImm;                 // ashui left
                    4'b0011: aluOp = aluAshrImm;                // ashui right
                    4'b0100: begin aluOp = aluLsh;  immKind = immNone; end
                    4'b0110: begin aluOp = aluAshu; immKind = immNone; end
                    default: regWrite = 1'b0;
                endcase
            end
            opBcond: begin
                aluOp   = aluBcond;
                immKind = immSigned;                            // displacement
            end
            opAndi:  begin aluOp = aluAnd; psrEn = enLogic; immKind = immZero; end
            opOri:   begin aluOp = aluOr;  psrEn = enLogic; immKind = immZero; end
            opXori:  begin aluOp = aluXor; psrEn = enLogic; immKind = immZero; end
            opAddi:  begin psrEn = enArith; immKind = immSigned; end
            opAddui: immKind = immSigned;
            opSubi:  begin aluOp = aluSub; psrEn = enArith; immKind = immSigned; end
            opCmpi:  begin aluOp = aluSub; psrEn = enCmp;   immKind = immSigned; end
            opMovi:  begin aluOp = aluMov; immKind = immSigned; end
            opMuli:  begin aluOp = aluMul; immKind = immSigned; end
            opLui:   begin aluOp = aluLui; immKind = immZero; end
            default: aluOp = aluAdd;
        endcase
        // every immediate form writes dst, cmpi excepted
        if (oper inside {opAndi, opOri, opXori, opAddi, opAddui, opSubi,
                         opMovi, opMuli, opLui})
            regWrite = 1'b1;
    end

    // immediate forms never reach flow control
    always_comb begin
        if (oper inside {opAndi, opOri, opXori, opAddi, opAddui, opSubi,
                         opCmpi, opMovi, opMuli, opLui})
            assert (!(aluOp inside {aluScond, aluBcond, aluJcond}))
                else $error("immediate form decoded to a flow-control op");
    end

endmodule

/* hw/cr16Core.sv */
module cr16Core (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [cr16Pkg::dataW-1:0]    instr,
    input  logic                         instrValid,
    output logic                         busy,
    output logic                         done,
    output logic                         wrEn,
    output logic [cr16Pkg::regAddrW-1:0] wrAddr,
    output logic [cr16Pkg::dataW-1:0]    wrData,
    output logic [cr16Pkg::psrW-1:0]     psr,
    output logic [cr16Pkg::dataW-1:0]    pc
);
    import cr16Pkg::*;

    logic             execStb;
    logic             writeStb;
    logic [dataW-1:0] instrQ;
    aluOpT            aluOp;
    logic [psrW-1:0]  psrEn;
    immKindT          immKind;
    logic             regWrite;
    condT             condSel;
    logic [dataW-1:0] dstVal;
    logic [dataW-1:0] srcVal;
    logic             takeJump;
    logic [dataW-1:0] jumpTarget;

    ////////////////////////////////////////////////////////////////////////////
    // sequencing and decode
    ////////////////////////////////////////////////////////////////////////////
    execCtrl u_execCtrl (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .latchOp    (),             // only used inside for the capture
        .execStb    (execStb),
        .writeStb   (writeStb),
        .busy       (busy),
        .done       (done),
        .instrQ     (instrQ)
    );

    aluController u_aluController (
        .oper     (operT'(instrQ[15:12])),
        .func     (instrQ[7:4]),
        .aluOp    (aluOp),
        .psrEn    (psrEn),
        .immKind  (immKind),
        .regWrite (regWrite)
    );

    // scond keeps cond in the src slot, bcond and jcond in the dst slot
    assign condSel = condT'((aluOp == aluScond) ? instrQ[3:0] : instrQ[11:8]);

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////
    regFile u_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (instrQ[11:8]),
        .rdAddrB (instrQ[3:0]),
        .rdDataA (dstVal),
        .rdDataB (srcVal),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    execUnit u_execUnit (
        .clk        (clk),
        .arstN      (arstN),
        .execStb    (execStb),
        .aluOp      (aluOp),
        .psrEn      (psrEn),
        .immKind    (immKind),
        .imm        (instrQ[7:0]),
        .dstVal     (dstVal),
        .srcVal     (srcVal),
        .cond       (condSel),
        .pcVal      (pc),
        .result     (wrData),
        .psr        (psr),
        .takeJump   (takeJump),
        .jumpTarget (jumpTarget)
    );

    progCounter u_progCounter (
        .clk    (clk),
        .arstN  (arstN),
        .step   (writeStb),
        .load   (takeJump),
        .target (jumpTarget),
        .pc     (pc)
    );

    assign wrEn   = writeStb && regWrite;
    assign wrAddr = instrQ[11:8];   // dst field

endmodule

/* hw/cr16Pkg.sv */
package cr16Pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and flag layout
    ////////////////////////////////////////////////////////////////////////////
    localparam int dataW    = 16;
    localparam int regAddrW = 4;
    localparam int psrW     = 5;    // C L F Z N, high to low

    localparam int flagC = 4;       // carry / borrow
    localparam int flagL = 3;       // unsigned lower
    localparam int flagF = 2;       // signed overflow
    localparam int flagZ = 1;
    localparam int flagN = 0;

    // flag-enable masks
    localparam logic [psrW-1:0] enArith = 5'b10111;  // C F Z N
    localparam logic [psrW-1:0] enCmp   = 5'b01011;  // L Z N
    localparam logic [psrW-1:0] enLogic = 5'b00010;  // Z only

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////
    // oper field, bits 15..12; codes 0110 and 1010 (addci, subci) stay unnamed
    typedef enum logic [3:0] {
        opReg     = 4'b0000,
        opAndi    = 4'b0001,
        opOri     = 4'b0010,
        opXori    = 4'b0011,
        opSpecial = 4'b0100,
        opAddi    = 4'b0101,
        opAddui   = 4'b0111,
        opShift   = 4'b1000,
        opSubi    = 4'b1001,
        opCmpi    = 4'b1011,
        opBcond   = 4'b1100,
        opMovi    = 4'b1101,
        opMuli    = 4'b1110,
        opLui     = 4'b1111
    } operT;

    // alu operation codes, controller table order
    typedef enum logic [4:0] {
        aluAdd     = 5'b00000,
        aluSub     = 5'b00001,
        aluMul     = 5'b00010,
        aluAnd     = 5'b00011,
        aluOr      = 5'b00100,
        aluXor     = 5'b00101,
        aluScond   = 5'b00111,
        aluMov     = 5'b01000,
        aluLui     = 5'b01001,
        aluNot     = 5'b01010,
        aluLsh     = 5'b01011,
        aluShlImm  = 5'b01100,
        aluShrImm  = 5'b01101,
        aluAshu    = 5'b01110,
        aluAshrImm = 5'b01111,
        aluBcond   = 5'b10000,
        aluJcond   = 5'b10001
    } aluOpT;

    typedef enum logic [3:0] {
        condEq, condNe, condCs, condCc, condHi, condLs, condGt, condLe,
        condFs, condFc, condLo, condHs, condLt, condGe, condUc, condNv
    } condT;

    typedef enum logic [1:0] {
        immNone,    // operand from src register
        immSigned,  // sext bits 7..0
        immZero,    // zext bits 7..0
        immShamt    // zext bits 3..0
    } immKindT;

    typedef enum logic [1:0] {sIdle, sDecode, sExec, sWrite} stateT;

endpackage

/* hw/execCtrl.sv */
module execCtrl (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      instrValid,
    input  logic [cr16Pkg::dataW-1:0] instr,
    output logic                      latchOp,
    output logic                      execStb,
    output logic                      writeStb,
    output logic                      busy,
    output logic                      done,
    output logic [cr16Pkg::dataW-1:0] instrQ
);
    import cr16Pkg::*;

    stateT state;
    stateT stateNext;

    // idle -> decode -> exec -> write -> idle
    always_comb begin
        case (state)
            sIdle:   stateNext = instrValid ? sDecode : sIdle;
            sDecode: stateNext = sExec;     // reg reads settle from instrQ
            sExec:   stateNext = sWrite;
            default: stateNext = sIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            state <= sIdle;
        else
            state <= stateNext;
    end

    // strobe while busy is simply not looked at
    always_ff @(posedge clk) begin
        if (latchOp)
            instrQ <= instr;
    end

    assign latchOp  = (state == sIdle) && instrValid;
    assign execStb  = (state == sExec);
    assign writeStb = (state == sWrite);
    assign done     = writeStb;
    assign busy     = (state != sIdle);

    assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else $error("done held for two cycles");

endmodule

/* hw/execUnit.sv */
module execUnit (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      execStb,
    input  cr16Pkg::aluOpT            aluOp,
    input  logic [cr16Pkg::psrW-1:0]  psrEn,
    input  cr16Pkg::immKindT          immKind,
    input  logic [7:0]                imm,
    input  logic [cr16Pkg::dataW-1:0] dstVal,
    input  logic [cr16Pkg::dataW-1:0] srcVal,
    input  cr16Pkg::condT             cond,
    input  logic [cr16Pkg::dataW-1:0] pcVal,
    output logic [cr16Pkg::dataW-1:0] result,
    output logic [cr16Pkg::psrW-1:0]  psr,
    output logic                      takeJump,
    output logic [cr16Pkg::dataW-1:0] jumpTarget
);
    import cr16Pkg::*;

    logic [dataW-1:0] opB;          // src or extended immediate
    logic [dataW:0]   sum;          // carry in msb
    logic [dataW:0]   diff;         // borrow in msb
    logic [dataW-1:0] shAmt;        // magnitude of a negative shift count
    logic [dataW-1:0] ashrNeg;
    logic [dataW-1:0] resNext;
    logic [psrW-1:0]  flagsNext;
    logic             condTrue;
    logic [dataW-1:0] targetNext;

    always_comb begin
        case (immKind)
            immSigned: opB = {{8{imm[7]}}, imm};
            immZero:   opB = {8'h00, imm};
            immShamt:  opB = {12'h000, imm[3:0]};
            default:   opB = srcVal;
        endcase
    end

    assign sum     = {1'b0, dstVal} + {1'b0, opB};
    assign diff    = {1'b0, dstVal} - {1'b0, opB};
    assign shAmt   = -opB;
    assign ashrNeg = $signed(dstVal) >>> shAmt[3:0];    // arithmetic right by the magnitude

    ////////////////////////////////////////////////////////////////////////////
    // condition check against the flags already in psr
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (cond)
            condEq:  condTrue = psr[flagZ];
            condNe:  condTrue = !psr[flagZ];
            condCs:  condTrue = psr[flagC];
            condCc:  condTrue = !psr[flagC];
            condHi:  condTrue = psr[flagL];
            condLs:  condTrue = !psr[flagL];
            condGt:  condTrue = psr[flagN];
            condLe:  condTrue = !psr[flagN];
            condFs:  condTrue = psr[flagF];
            condFc:  condTrue = !psr[flagF];
            condLo:  condTrue = !psr[flagL] && !psr[flagZ];
            condHs:  condTrue = psr[flagL] || psr[flagZ];
            condLt:  condTrue = !psr[flagN] && !psr[flagZ];
            condGe:  condTrue = psr[flagN] || psr[flagZ];
            condUc:  condTrue = 1'b1;
            default: condTrue = 1'b0;                       // nv
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (aluOp)
            aluAdd:     resNext = sum[dataW-1:0];
            aluSub:     resNext = diff[dataW-1:0];
            aluMul:     resNext = dstVal * opB;             // low 16 bits
            aluAnd:     resNext = dstVal & opB;
            aluOr:      resNext = dstVal | opB;
            aluXor:     resNext = dstVal ^ opB;
            aluScond:   resNext = {{(dataW-1){1'b0}}, condTrue};
            aluMov:     resNext = opB;
            aluLui:     resNext = {opB[7:0], dstVal[7:0]};
            aluNot:     resNext = ~dstVal;
            aluShlImm:  resNext = dstVal << opB[3:0];
            aluShrImm:  resNext = dstVal >> opB[3:0];
            aluAshrImm: resNext = $signed(dstVal) >>> opB[3:0];
            // negative count shifts right by its magnitude
            aluLsh:     resNext = opB[dataW-1] ? dstVal >> shAmt[3:0] : dstVal << opB[3:0];
            aluAshu:    resNext = opB[dataW-1] ? ashrNeg : dstVal << opB[3:0];
            default:    resNext = dstVal;                   // bcond, jcond
        endcase
    end

    // candidate flags; psrEn decides which land
    always_comb begin
        flagsNext        = '0;
        flagsNext[flagZ] = (resNext == '0);
        if (aluOp == aluSub) begin
            flagsNext[flagC] = diff[dataW];
            flagsNext[flagL] = dstVal < opB;
            flagsNext[flagF] = (dstVal[15] != opB[15]) && (diff[15] != dstVal[15]);
            flagsNext[flagN] = $signed(dstVal) < $signed(opB);
        end else begin
            flagsNext[flagC] = sum[dataW];
            flagsNext[flagF] = (dstVal[15] == opB[15]) && (sum[15] != dstVal[15]);
            flagsNext[flagN] = resNext[dataW-1];
        end
    end

    // jcond has opB = src since it decodes with no immediate
    assign targetNext = (aluOp == aluBcond) ? pcVal + opB : opB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            psr      <= '0;
            takeJump <= 1'b0;
        end else if (execStb) begin
            psr      <= (psr & ~psrEn) | (flagsNext & psrEn);
            takeJump <= condTrue && (aluOp inside {aluBcond, aluJcond});
        end
    end

    always_ff @(posedge clk) begin
        if (execStb) begin
            result     <= resNext;
            jumpTarget <= targetNext;
        end
    end

    // flags outside the mask survive an execute
    assert property (@(posedge clk) disable iff (!arstN)
        execStb |=> ((psr & ~$past(psrEn)) == ($past(psr) & ~$past(psrEn))))
        else $error("psr bit changed outside psrEn");

endmodule

/* hw/progCounter.sv */
module progCounter (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      step,
    input  logic                      load,
    input  logic [cr16Pkg::dataW-1:0] target,
    output logic [cr16Pkg::dataW-1:0] pc
);

    // one update per finished instruction, wraps at 16 bits
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pc <= '0;
        else if (step)
            pc <= load ? target : pc + 16'd1;   // taken branch or next
    end

endmodule

/* hw/regFile.sv */
module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [cr16Pkg::regAddrW-1:0] rdAddrA,
    input  logic [cr16Pkg::regAddrW-1:0] rdAddrB,
    output logic [cr16Pkg::dataW-1:0]    rdDataA,
    output logic [cr16Pkg::dataW-1:0]    rdDataB,
    input  logic                         wrEn,
    input  logic [cr16Pkg::regAddrW-1:0] wrAddr,
    input  logic [cr16Pkg::dataW-1:0]    wrData
);
    import cr16Pkg::*;

    logic [dataW-1:0] regs [2**regAddrW];

    // reads are plain muxes, no bypass from the write port
    assign rdDataA = regs[rdAddrA];     // dst operand
    assign rdDataB = regs[rdAddrB];     // src operand

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++)
                regs[i] <= '0;
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tbCr16Core -o simTb
out=$(./obj_dir/simTb)
echo "$out"
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

/* sim/tbCr16Core.sv */
module tbCr16Core;
    timeunit 1ns;
    timeprecision 1ps;
    import cr16Pkg::*;

    localparam int numRandom = 300;
    localparam int numInstr  = numRandom + 80;                 // directed ones rounded up
    localparam int limitNs   = numInstr * 5 * 8 + 200;

    logic        clk;
    logic        arstN;
    logic [15:0] instr;
    logic        instrValid;
    logic        busy;
    logic        done;
    logic        wrEn;
    logic [3:0]  wrAddr;
    logic [15:0] wrData;
    logic [4:0]  psr;
    logic [15:0] pc;

    int          errors = 0;
    logic [15:0] mRegs [16];                                   // model state
    logic [4:0]  mPsr;
    logic [15:0] mPc;
    logic [15:0] pendIns [$];                                  // issued, not yet done
    string       pendName [$];
    logic [31:0] lfsrState = 32'd96642;
    logic [15:0] kindBase [30];                                // legal encodings
    logic [15:0] kindMask [30];                                // random field bits

    // directed sequences
    logic [15:0] arithSeq [9] = '{16'hD2FF, 16'hF27F, 16'hD301, 16'h0253, 16'h0493,
                                 16'h03B3, 16'h0273, 16'hB305, 16'h9301};
    logic [15:0] logicSeq [17] = '{16'hD50F, 16'h153C, 16'h25F0, 16'h35FF, 16'h0645,
                                  16'h05F6, 16'h8503, 16'h8512, 16'h8521, 16'hD780,
                                  16'h8734, 16'hD8FD, 16'h8748, 16'h8768, 16'hD902,
                                  16'h8749, 16'h8769};
    logic [15:0] flowSeq [8] = '{16'hCE05, 16'hCF05, 16'h03B3, 16'hC0FC, 16'hC1FC,
                                16'hDB40, 16'h4ECB, 16'h4FCB};
    logic [3:0]  regFuncs [11] = '{1, 2, 3, 4, 5, 7, 9, 11, 13, 14, 15};
    logic [3:0]  immOpers [10] = '{1, 2, 3, 5, 7, 9, 11, 13, 14, 15};
    logic [3:0]  shFuncs [6] = '{0, 1, 2, 3, 4, 6};

    cr16Core u_cr16Core (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .busy       (busy),
        .done       (done),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .psr        (psr),
        .pc         (pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic b;
        b = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (b)
            lfsrState = lfsrState ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [15:0] randBits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], lfsrBit()};
        return v;
    endfunction

    function automatic logic condHolds(condT c, logic [4:0] p);
        case (c)
            condEq:  return p[flagZ];
            condNe:  return !p[flagZ];
            condCs:  return p[flagC];
            condCc:  return !p[flagC];
            condHi:  return p[flagL];
            condLs:  return !p[flagL];
            condGt:  return p[flagN];
            condLe:  return !p[flagN];
            condFs:  return p[flagF];
            condFc:  return !p[flagF];
            condLo:  return !p[flagL] && !p[flagZ];
            condHs:  return p[flagL] || p[flagZ];
            condLt:  return !p[flagN] && !p[flagZ];
            condGe:  return p[flagN] || p[flagZ];
            condUc:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model, one instruction against mRegs, mPsr, mPc
    ////////////////////////////////////////////////////////////////////////////
    function automatic void applyInstr(input logic [15:0] ins, output logic eWr,
                                       output logic [3:0] eAddr, output logic [15:0] eData,
                                       output logic [4:0] ePsr, output logic [15:0] ePc);
        operT        op;
        logic [3:0]  fn;
        logic [15:0] dv;
        logic [15:0] sv;
        logic [15:0] sx;
        logic [15:0] zx;
        logic [15:0] b;
        logic [15:0] r;
        logic [15:0] mag;
        logic [15:0] tgt;
        logic        jmp;
        int          kind;                                     // 1 add 2 sub 3 cmp 4 logic
        op   = operT'(ins[15:12]);
        fn   = ins[7:4];
        dv   = mRegs[ins[11:8]];
        sv   = mRegs[ins[3:0]];
        sx   = {{8{ins[7]}}, ins[7:0]};
        zx   = {8'h00, ins[7:0]};
        b    = sv;
        r    = '0;
        eWr  = 1'b1;
        kind = 0;
        jmp  = 1'b0;
        tgt  = '0;
        case (op)
            opReg: begin
                case (fn)
                    4'h1: begin r = dv & b; kind = 4; end
                    4'h2: begin r = dv | b; kind = 4; end
                    4'h3: begin r = dv ^ b; kind = 4; end
                    4'h4: begin r = ~dv; kind = 4; end
                    4'h5: begin r = dv + b; kind = 1; end
                    4'h7: r = dv + b;                          // addu, no flags
                    4'h9: begin r = dv - b; kind = 2; end
                    4'hB: begin r = dv - b; kind = 3; eWr = 1'b0; end
                    4'hD: r = b;
                    4'hE: r = dv * b;
                    4'hF: begin r = dv & b; kind = 4; eWr = 1'b0; end
                    default: eWr = 1'b0;
                endcase
            end
            opAndi:  begin b = zx; r = dv & b; kind = 4; end
            opOri:   begin b = zx; r = dv | b; kind = 4; end
            opXori:  begin b = zx; r = dv ^ b; kind = 4; end
            opAddi:  begin b = sx; r = dv + b; kind = 1; end
            opAddui: r = dv + sx;
            opSubi:  begin b = sx; r = dv - b; kind = 2; end
            opCmpi:  begin b = sx; r = dv - b; kind = 3; eWr = 1'b0; end
            opMovi:  r = sx;
            opMuli:  r = dv * sx;
            opLui:   r = {ins[7:0], dv[7:0]};
            opShift: begin
                mag = -sv;                                     // magnitude when negative
                case (fn)
                    4'h0, 4'h2: r = dv << ins[3:0];
                    4'h1: r = dv >> ins[3:0];
                    4'h3: r = $signed(dv) >>> ins[3:0];
                    4'h4: begin
                        if (sv[15])
                            r = dv >> mag[3:0];
                        else
                            r = dv << sv[3:0];
                    end
                    4'h6: begin
                        if (sv[15])
                            r = $signed(dv) >>> mag[3:0];
                        else
                            r = dv << sv[3:0];
                    end
                    default: eWr = 1'b0;
                endcase
            end
            opSpecial: begin
                if (fn == 4'hD) begin
                    r = {15'h0, condHolds(condT'(ins[3:0]), mPsr)};   // scond
                end else begin
                    eWr = 1'b0;
                    jmp = (fn == 4'hC) && condHolds(condT'(ins[11:8]), mPsr);
                    tgt = sv;                                  // jcond
                end
            end
            opBcond: begin
                eWr = 1'b0;
                jmp = condHolds(condT'(ins[11:8]), mPsr);
                tgt = mPc + sx;
            end
            default: eWr = 1'b0;
        endcase
        case (kind)
            1: begin
                mPsr[flagC] = ({1'b0, dv} + {1'b0, b}) > 17'h0FFFF;
                mPsr[flagF] = (dv[15] == b[15]) && (r[15] != dv[15]);
                mPsr[flagZ] = (r == 16'h0);
                mPsr[flagN] = r[15];
            end
            2: begin
                mPsr[flagC] = dv < b;                          // borrow
                mPsr[flagF] = (dv[15] != b[15]) && (r[15] != dv[15]);
                mPsr[flagZ] = (r == 16'h0);
                mPsr[flagN] = $signed(dv) < $signed(b);
            end
            3: begin
                mPsr[flagL] = dv < b;
                mPsr[flagZ] = (r == 16'h0);
                mPsr[flagN] = $signed(dv) < $signed(b);
            end
            4: mPsr[flagZ] = (r == 16'h0);
            default: ;
        endcase
        mPc   = jmp ? tgt : mPc + 16'h1;
        eAddr = ins[11:8];
        eData = r;
        if (eWr)
            mRegs[ins[11:8]] = r;
        ePsr = mPsr;
        ePc  = mPc;
    endfunction

    task automatic checkField(string testName, string field, logic [15:0] exp,
                              logic [15:0] act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s %s expected %h actual %h", testName, field, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [15:0] ins;
        string       nm;
        logic        eWr;
        logic [3:0]  eAddr;
        logic [15:0] eData;
        logic [4:0]  ePsr;
        logic [15:0] ePc;
        forever begin
            @(negedge clk);
            if (done) begin
                if (pendIns.size() == 0) begin
                    errors++;
                    $display("done seen with no instruction outstanding");
                end else begin
                    ins = pendIns.pop_front();
                    nm  = pendName.pop_front();
                    applyInstr(ins, eWr, eAddr, eData, ePsr, ePc);
                    checkField(nm, "busy", 16'h1, 16'(busy));
                    checkField(nm, "wrEn", 16'(eWr), 16'(wrEn));
                    if (eWr) begin
                        checkField(nm, "wrAddr", 16'(eAddr), 16'(wrAddr));
                        checkField(nm, "wrData", eData, wrData);
                    end
                    @(negedge clk);                            // past the write edge
                    checkField(nm, "psr", 16'(ePsr), 16'(psr));
                    checkField(nm, "pc", ePc, pc);
                    checkField(nm, "busy", 16'h0, 16'(busy));
                end
            end
        end
    end

    // starts and ends on a rising edge
    task automatic runInstr(string name, logic [15:0] ins, logic pulse);
        int waits;
        pendIns.push_back(ins);
        pendName.push_back(name);
        instr      <= ins;
        instrValid <= 1'b1;
        @(posedge clk);                                        // captured here
        instrValid <= 1'b0;
        if (pulse) begin
            instr      <= randBits(16);                        // must be dropped
            instrValid <= 1'b1;
            @(posedge clk);
            instrValid <= 1'b0;
        end
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!done && waits < 8);
        if (!done) begin
            errors++;
            $display("%s: no done within 8 cycles", name);
        end
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed and random stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int          n;
        int          k;
        logic [15:0] ins;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        mPsr       = '0;
        mPc        = '0;
        foreach (mRegs[i])
            mRegs[i] = '0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkField("reset", "psr", 16'h0, 16'(psr));
        checkField("reset", "pc", 16'h0, pc);
        checkField("reset", "done", 16'h0, 16'(done));
        checkField("reset", "busy", 16'h0, 16'(busy));
        checkField("reset", "wrEn", 16'h0, 16'(wrEn));
        @(posedge clk);
        runInstr("mov r0", 16'h01D0, 1'b0);
        foreach (arithSeq[i])
            runInstr("arith", arithSeq[i], 1'b0);
        foreach (logicSeq[i])
            runInstr("logic shift", logicSeq[i], 1'b0);
        runInstr("scond setup", 16'h03B4, 1'b0);             // cmp 0, 0xffff
        for (int c = 0; c < 16; c++)
            runInstr("scond", 16'h4AD0 | 16'(c), 1'b0);
        runInstr("scond setup", 16'h03B3, 1'b0);             // equal operands
        for (int c = 0; c < 16; c++)
            runInstr("scond", 16'h4AD0 | 16'(c), 1'b0);
        foreach (flowSeq[i])
            runInstr("branch", flowSeq[i], 1'b0);
        // random table, field bits filled from the lfsr
        n = 0;
        foreach (regFuncs[i]) begin
            kindBase[n] = {8'h00, regFuncs[i], 4'h0};
            kindMask[n] = 16'h0F0F;
            n++;
        end
        foreach (immOpers[i]) begin
            kindBase[n] = {immOpers[i], 12'h000};
            kindMask[n] = 16'h0FFF;
            n++;
        end
        foreach (shFuncs[i]) begin
            kindBase[n] = {8'h80, shFuncs[i], 4'h0};
            kindMask[n] = 16'h0F0F;
            n++;
        end
        kindBase[27] = 16'h40D0;                               // scond
        kindMask[27] = 16'h0F0F;
        kindBase[28] = 16'hC000;                               // bcond
        kindMask[28] = 16'h0FFF;
        kindBase[29] = 16'h40C0;                               // jcond
        kindMask[29] = 16'h0F0F;
        for (int i = 0; i < numRandom; i++) begin
            k   = int'(randBits(5)) % 30;
            ins = kindBase[k] | (randBits(16) & kindMask[k]);
            runInstr("random", ins, (i % 7) == 3);
        end
        @(negedge clk);
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // watchdog
    initial begin
        #(limitNs * 1ns);
        $display("timeout: run did not finish in %0d ns", limitNs);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* tb.f */
hw/cr16Pkg.sv
hw/aluController.sv
hw/execUnit.sv
hw/regFile.sv
hw/execCtrl.sv
hw/progCounter.sv
hw/cr16Core.sv
sim/tbCr16Core.sv
